// ==== design/axi_pkg.sv ====
package axi_pkg;

   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int AXI_LEN_W  = 8;

   // Attribute codes, identical for every burst
   localparam logic [1:0] AXI_BURST_INCR = 2'd1;
   localparam logic [2:0] AXI_SIZE_4B    = 3'd2;
   localparam logic [3:0] AXI_CACHE_BUF  = 4'd2;
   // Unprivileged, non-secure, data access
   localparam logic [2:0] AXI_PROT_DATA  = 3'd2;

   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_LEN_W-1:0]  len;
      logic [2:0]            size;
      logic [1:0]            burst;
      logic [3:0]            cache;
      logic [2:0]            prot;
   } axi_aw_t;

   typedef struct packed {
      logic [AXI_DATA_W-1:0]   data;
      logic [AXI_DATA_W/8-1:0] strb;
      logic                    last;
   } axi_w_t;

   typedef struct packed {
      logic [1:0] resp;
   } axi_b_t;

endpackage

// ==== design/eth_dma_pkg.sv ====
package eth_dma_pkg;

   // Byte count of one copy, 1 to 1020
   localparam int DMA_LEN_W  = 10;
   // Word address into the 512-word frame buffer
   localparam int BUF_ADDR_W = 9;

   typedef struct packed {
      logic [axi_pkg::AXI_ADDR_W-1:0] addr;
      logic [DMA_LEN_W-1:0]           len;
   } dma_cfg_t;

   // MAC side write port
   typedef struct packed {
      logic                  we;
      logic [BUF_ADDR_W-1:0] addr;
      logic [31:0]           data;
   } buf_wr_t;

endpackage

// ==== design/eth_rx_buffer.sv ====
`timescale 1ns/1ps

module eth_rx_buffer (
   input  logic                               clk,
   input  eth_dma_pkg::buf_wr_t               wr,
   input  logic [eth_dma_pkg::BUF_ADDR_W-1:0] rd_addr,
   output logic [31:0]                        rd_data
);

   import eth_dma_pkg::*;

   localparam int DEPTH = 1 << BUF_ADDR_W;

   logic [31:0] mem [DEPTH];

   // MAC side fills the frame one word at a time
   always_ff @(posedge clk) begin
      if (wr.we) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // Registered read, data valid one cycle after rd_addr
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== design/eth_burst_split.sv ====
`timescale 1ns/1ps

module eth_burst_split (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [31:0]                       in_word,
   input  logic                              advance,
   input  logic [1:0]                        offset,
   input  logic [eth_dma_pkg::DMA_LEN_W-1:0] len,
   output logic [31:0]                       out_word,
   output logic [3:0]                        first_strb,
   output logic [3:0]                        last_strb,
   output logic [7:0]                        beats_m1
);

   import eth_dma_pkg::*;

   logic [31:0]          prev_word;
   logic [DMA_LEN_W:0]   span;
   logic [DMA_LEN_W-2:0] beats;
   logic [1:0]           end_lane;

   // Previous buffer word supplies the low lanes of the next beat
   always_ff @(posedge clk) begin
      if (advance) begin
         prev_word <= in_word;
      end
   end

   // Frame byte 0 lands on lane offset
   always_comb begin
      case (offset)
         2'd0:    out_word = in_word;
         2'd1:    out_word = {in_word[23:0], prev_word[31:24]};
         2'd2:    out_word = {in_word[15:0], prev_word[31:16]};
         default: out_word = {in_word[7:0], prev_word[31:8]};
      endcase
   end

   // Beats = (offset + len + 3) / 4
   assign span = (DMA_LEN_W+1)'(offset) + (DMA_LEN_W+1)'(len) + (DMA_LEN_W+1)'(3);
   assign beats = span[DMA_LEN_W:2];
   assign beats_m1 = 8'(beats - 1'b1);

   // Lane of the final frame byte, wraps mod 4
   assign end_lane = offset + len[1:0] - 2'd1;

   assign first_strb = 4'b1111 << offset;
   assign last_strb = 4'b1111 >> (2'd3 - end_lane);

   // An empty copy must never reach the data path
   a_no_advance_empty: assert property (
      @(posedge clk) disable iff (rst) advance |-> len != '0
   ) else $error("realigner advanced with zero length");

endmodule

// ==== design/eth_dma_w.sv ====
`timescale 1ns/1ps

module eth_dma_w #(
   parameter int unsigned BUF_START = 0
) (
   input  logic                               clk,
   input  logic                               rst,
   input  eth_dma_pkg::dma_cfg_t              cfg,
   input  logic                               run,
   output logic                               ready,
   output logic [eth_dma_pkg::BUF_ADDR_W-1:0] rd_addr,
   input  logic [31:0]                        rd_data,
   output axi_pkg::axi_aw_t                   aw,
   output logic                               aw_valid,
   input  logic                               aw_ready,
   output axi_pkg::axi_w_t                    w,
   output logic                               w_valid,
   input  logic                               w_ready,
   input  axi_pkg::axi_b_t                    b,
   input  logic                               b_valid,
   output logic                               b_ready
);

   import axi_pkg::*;
   import eth_dma_pkg::*;

   typedef enum logic [6:0] {
      ST_IDLE      = 7'b0000001,
      ST_PREFETCH  = 7'b0000010,
      ST_ADDRESS   = 7'b0000100,
      ST_BOOTSTRAP = 7'b0001000,
      ST_BURST     = 7'b0010000,
      ST_LAST      = 7'b0100000,
      ST_RESPONSE  = 7'b1000000
   } state_t;

   state_t               state;
   logic [AXI_ADDR_W-1:0] aw_addr_q;
   logic [AXI_LEN_W-1:0]  aw_len_q;
   logic [31:0]           w_data_q;
   logic [3:0]            w_strb_q;
   logic                  w_last_q;
   logic [AXI_LEN_W-1:0]  beat_cnt;
   logic [AXI_LEN_W-1:0]  next_cnt;
   logic [31:0]           store_word;
   logic                  has_store;
   logic                  w_fire;
   logic                  advance;
   logic                  single_beat;
   logic                  last_next;
   logic [31:0]           in_word;
   logic [31:0]           out_word;
   logic [3:0]            first_strb;
   logic [3:0]            last_strb;
   logic [7:0]            beats_m1;

   assign w_fire = w_valid & w_ready;
   assign next_cnt = beat_cnt + 8'd1;
   assign single_beat = (aw_len_q == '0);
   assign last_next = (next_cnt == aw_len_q);

   // Held word wins after a stall
   assign in_word = has_store ? store_word : rd_data;
   assign advance = (state == ST_BOOTSTRAP) | ((state == ST_BURST) & w_fire);

   eth_burst_split u_split (
      .clk        (clk),
      .rst        (rst),
      .in_word    (in_word),
      .advance    (advance),
      .offset     (cfg.addr[1:0]),
      .len        (cfg.len),
      .out_word   (out_word),
      .first_strb (first_strb),
      .last_strb  (last_strb),
      .beats_m1   (beats_m1)
   );

   assign aw = '{addr: aw_addr_q, len: aw_len_q, size: AXI_SIZE_4B,
                 burst: AXI_BURST_INCR, cache: AXI_CACHE_BUF, prot: AXI_PROT_DATA};
   assign w = '{data: w_data_q, strb: w_strb_q, last: w_last_q};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= ST_IDLE;
         ready     <= 1'b1;
         aw_valid  <= 1'b0;
         w_valid   <= 1'b0;
         w_last_q  <= 1'b0;
         b_ready   <= 1'b0;
         has_store <= 1'b0;
         beat_cnt  <= '0;
         rd_addr   <= BUF_ADDR_W'(BUF_START);
      end else begin
         case (state)
            ST_IDLE: begin
               rd_addr   <= BUF_ADDR_W'(BUF_START);
               has_store <= 1'b0;
               if (run) begin
                  ready <= 1'b0;
                  state <= ST_PREFETCH;
               end
            end
            // First buffer word is being read
            ST_PREFETCH: begin
               aw_valid <= 1'b1;
               state    <= ST_ADDRESS;
            end
            ST_ADDRESS: begin
               if (aw_ready) begin
                  aw_valid <= 1'b0;
                  rd_addr  <= rd_addr + 1'b1;
                  state    <= ST_BOOTSTRAP;
               end
            end
            // Word 0 primes the realigner, beat 0 is loaded
            ST_BOOTSTRAP: begin
               w_valid  <= 1'b1;
               w_last_q <= single_beat;
               beat_cnt <= '0;
               rd_addr  <= rd_addr + 1'b1;
               state    <= single_beat ? ST_LAST : ST_BURST;
            end
            ST_BURST: begin
               if (w_fire) begin
                  beat_cnt  <= next_cnt;
                  rd_addr   <= rd_addr + 1'b1;
                  has_store <= 1'b0;
                  if (last_next) begin
                     w_last_q <= 1'b1;
                     state    <= ST_LAST;
                  end
               end else if (!has_store) begin
                  // Read already moved on, keep this word
                  has_store <= 1'b1;
               end
            end
            ST_LAST: begin
               if (w_fire) begin
                  w_valid  <= 1'b0;
                  w_last_q <= 1'b0;
                  b_ready  <= 1'b1;
                  state    <= ST_RESPONSE;
               end
            end
            ST_RESPONSE: begin
               if (b_valid) begin
                  b_ready <= 1'b0;
                  ready   <= 1'b1;
                  state   <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE) begin
         aw_addr_q <= {cfg.addr[AXI_ADDR_W-1:2], 2'b00};
         aw_len_q  <= beats_m1;
      end
      if (state == ST_BOOTSTRAP) begin
         w_data_q <= out_word;
         w_strb_q <= single_beat ? (first_strb & last_strb) : first_strb;
      end else if ((state == ST_BURST) && w_fire) begin
         w_data_q <= out_word;
         w_strb_q <= last_next ? last_strb : 4'b1111;
      end
      if ((state == ST_BURST) && !w_fire && !has_store) begin
         store_word <= rd_data;
      end
   end

   a_w_after_aw: assert property (
      @(posedge clk) disable iff (rst) $rose(w_valid) |-> !aw_valid
   ) else $error("w_valid rose with address still pending");

   a_last_valid: assert property (
      @(posedge clk) disable iff (rst) w.last |-> w_valid
   ) else $error("w.last without w_valid");

   a_w_stable: assert property (
      @(posedge clk) disable iff (rst) w_valid && !w_ready |=> w_valid && $stable(w)
   ) else $error("W payload changed during stall");

   a_b_known: assert property (
      @(posedge clk) disable iff (rst) b_valid && b_ready |-> !$isunknown(b.resp)
   ) else $error("unknown write response");

endmodule

// ==== design/eth_dma_top.sv ====
`timescale 1ns/1ps

module eth_dma_top #(
   parameter int unsigned BUF_START = 0
) (
   input  logic                  clk,
   input  logic                  rst,
   input  eth_dma_pkg::buf_wr_t  buf_wr,
   input  eth_dma_pkg::dma_cfg_t cfg,
   input  logic                  run,
   output logic                  ready,
   output axi_pkg::axi_aw_t      aw,
   output logic                  aw_valid,
   input  logic                  aw_ready,
   output axi_pkg::axi_w_t       w,
   output logic                  w_valid,
   input  logic                  w_ready,
   input  axi_pkg::axi_b_t       b,
   input  logic                  b_valid,
   output logic                  b_ready
);

   import eth_dma_pkg::*;

   logic [BUF_ADDR_W-1:0] rd_addr;
   logic [31:0]           rd_data;

   eth_rx_buffer u_buffer (
      .clk     (clk),
      .wr      (buf_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   eth_dma_w #(
      .BUF_START (BUF_START)
   ) u_dma_w (
      .clk      (clk),
      .rst      (rst),
      .cfg      (cfg),
      .run      (run),
      .ready    (ready),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .aw       (aw),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .w        (w),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .b        (b),
      .b_valid  (b_valid),
      .b_ready  (b_ready)
   );

endmodule

// ==== bench/axi_mem_slave.sv ====
`timescale 1ns/1ps

module axi_mem_slave (
   input  logic             clk,
   input  logic             rst,
   input  logic             stall_en,
   input  logic             fill_en,
   input  logic [31:0]      fill_base,
   input  logic [11:0]      fill_count,
   input  axi_pkg::axi_aw_t aw,
   input  logic             aw_valid,
   output logic             aw_ready,
   input  axi_pkg::axi_w_t  w,
   input  logic             w_valid,
   output logic             w_ready,
   output axi_pkg::axi_b_t  b,
   output logic             b_valid,
   input  logic             b_ready
);

   import axi_pkg::*;

   // 8 KB of byte storage, upper address bits ignored
   logic [7:0]  mem [8192];
   logic [31:0] wr_addr;
   logic [1:0]  aw_wait;
   logic [1:0]  w_wait;
   logic [1:0]  b_wait;
   logic        b_pend;

   function automatic logic [1:0] draw_delay();
      return stall_en ? 2'($urandom_range(3, 0)) : 2'd0;
   endfunction

   assign aw_ready = (aw_wait == 2'd0);
   assign w_ready = (w_wait == 2'd0);
   assign b = '{resp: 2'b00};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         aw_wait <= '0;
         w_wait  <= '0;
         b_wait  <= '0;
         b_pend  <= 1'b0;
         b_valid <= 1'b0;
         wr_addr <= '0;
      end else begin
         if (aw_valid && aw_ready) begin
            wr_addr <= aw.addr;
            aw_wait <= draw_delay();
         end else if (aw_valid && aw_wait != 2'd0) begin
            aw_wait <= aw_wait - 2'd1;
         end
         if (w_valid && w_ready) begin
            wr_addr <= wr_addr + 32'd4;
            w_wait  <= draw_delay();
            if (w.last) begin
               b_pend <= 1'b1;
               b_wait <= draw_delay();
            end
         end else if (w_valid && w_wait != 2'd0) begin
            w_wait <= w_wait - 2'd1;
         end
         // Response waits out its own delay
         if (b_valid && b_ready) begin
            b_valid <= 1'b0;
         end else if (b_pend) begin
            if (b_wait == 2'd0) begin
               b_valid <= 1'b1;
               b_pend  <= 1'b0;
            end else begin
               b_wait <= b_wait - 2'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_en) begin
         for (int i = 0; i < int'(fill_count); i++) begin
            mem[13'(fill_base + 32'(i))] <= 8'hA5;
         end
      end
      if (w_valid && w_ready) begin
         for (int l = 0; l < 4; l++) begin
            if (w.strb[l]) begin
               mem[13'(wr_addr + 32'(l))] <= w.data[8*l +: 8];
            end
         end
      end
   end

endmodule

// ==== bench/tb_eth_dma.sv ====
`timescale 1ns/1ps

module tb_eth_dma;

   import axi_pkg::*;
   import eth_dma_pkg::*;

   localparam int BUF_START = 16;
   localparam int N_CASES = 13;

   typedef struct packed {
      logic [31:0] addr;
      logic [9:0]  len;
      logic        stall;
   } case_t;

   // Byte address, byte length, random back-pressure
   localparam case_t CASES [N_CASES] = '{
      '{32'h0000_0100, 10'd1,    1'b0},
      '{32'h0000_0201, 10'd2,    1'b0},
      '{32'h0000_0302, 10'd3,    1'b1},
      '{32'h0000_0403, 10'd4,    1'b1},
      '{32'h0000_0500, 10'd5,    1'b1},
      '{32'h0000_0603, 10'd5,    1'b0},
      '{32'h0000_0701, 10'd64,   1'b0},
      '{32'h0000_0802, 10'd64,   1'b1},
      '{32'h0000_0900, 10'd1020, 1'b0},
      '{32'h0000_0D03, 10'd1019, 1'b1},
      '{32'h0000_1201, 10'd1020, 1'b1},
      '{32'h0000_1702, 10'd1019, 1'b0},
      '{32'h0000_1C03, 10'd2,    1'b1}
   };

   logic        clk;
   logic        rst;
   buf_wr_t     buf_wr;
   dma_cfg_t    cfg;
   logic        run;
   logic        ready;
   axi_aw_t     aw;
   logic        aw_valid;
   logic        aw_ready;
   axi_w_t      w;
   logic        w_valid;
   logic        w_ready;
   axi_b_t      b;
   logic        b_valid;
   logic        b_ready;
   logic        stall_en;
   logic        fill_en;
   logic [31:0] fill_base;
   logic [11:0] fill_count;

   logic [7:0]  frame [1024];
   axi_aw_t     cap_aw;
   int          aw_cnt;
   int          w_cnt;
   int          b_cnt;
   int          last_cnt;
   int          last_pos;
   int          beat_idx;
   int          errors;
   int          failed_cases;

   eth_dma_top #(
      .BUF_START (BUF_START)
   ) u_dut (
      .clk      (clk),
      .rst      (rst),
      .buf_wr   (buf_wr),
      .cfg      (cfg),
      .run      (run),
      .ready    (ready),
      .aw       (aw),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .w        (w),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .b        (b),
      .b_valid  (b_valid),
      .b_ready  (b_ready)
   );

   axi_mem_slave u_mem (
      .clk        (clk),
      .rst        (rst),
      .stall_en   (stall_en),
      .fill_en    (fill_en),
      .fill_base  (fill_base),
      .fill_count (fill_count),
      .aw         (aw),
      .aw_valid   (aw_valid),
      .aw_ready   (aw_ready),
      .w          (w),
      .w_valid    (w_valid),
      .w_ready    (w_ready),
      .b          (b),
      .b_valid    (b_valid),
      .b_ready    (b_ready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Bus monitor, counts handshakes over the whole run
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         aw_cnt   <= 0;
         w_cnt    <= 0;
         b_cnt    <= 0;
         last_cnt <= 0;
         last_pos <= 0;
         beat_idx <= 0;
         cap_aw   <= '0;
      end else begin
         if (aw_valid && aw_ready) begin
            cap_aw   <= aw;
            aw_cnt   <= aw_cnt + 1;
            beat_idx <= 0;
         end
         if (w_valid && w_ready) begin
            w_cnt    <= w_cnt + 1;
            beat_idx <= beat_idx + 1;
            if (w.last) begin
               last_cnt <= last_cnt + 1;
               last_pos <= beat_idx;
            end
         end
         if (b_valid && b_ready) begin
            b_cnt <= b_cnt + 1;
         end
      end
   end

   task automatic report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic load_frame(input int len);
      int nwords;
      nwords = (len + 3) / 4;
      for (int i = 0; i < len; i++) begin
         frame[10'(i)] = 8'($urandom);
      end
      for (int k = 0; k < nwords; k++) begin
         @(posedge clk);
         #2;
         buf_wr.we   = 1'b1;
         buf_wr.addr = BUF_ADDR_W'(BUF_START + k);
         buf_wr.data = {frame[10'(4*k+3)], frame[10'(4*k+2)],
                        frame[10'(4*k+1)], frame[10'(4*k)]};
      end
      @(posedge clk);
      #2;
      buf_wr.we = 1'b0;
   endtask

   task automatic run_case(input int idx, input case_t tc);
      logic [31:0] base;
      logic [31:0] a;
      logic [7:0]  got;
      logic [7:0]  expect_byte;
      int          off;
      int          beats;
      int          aw0;
      int          w0;
      int          b0;
      int          last0;
      int          err0;
      logic        mem_bad;
      off = int'(tc.addr[1:0]);
      beats = (off + int'(tc.len) + 3) / 4;
      base = {tc.addr[31:2], 2'b00};
      err0 = errors;
      mem_bad = 1'b0;
      load_frame(int'(tc.len));
      fill_en    = 1'b1;
      fill_base  = base - 32'd4;
      fill_count = 12'(beats * 4 + 8);
      stall_en   = tc.stall;
      cfg.addr   = tc.addr;
      cfg.len    = tc.len;
      @(posedge clk);
      #2;
      fill_en = 1'b0;
      aw0 = aw_cnt;
      w0 = w_cnt;
      b0 = b_cnt;
      last0 = last_cnt;
      assert (ready) else report_error($sformatf("case %0d ready low before run", idx));
      run = 1'b1;
      @(posedge clk);
      #2;
      run = 1'b0;
      assert (!ready) else report_error($sformatf("case %0d ready high after run", idx));
      do begin
         @(posedge clk);
         #2;
      end while (!ready);

      assert (aw_cnt - aw0 == 1)
         else report_error($sformatf("case %0d saw %0d AW transfers", idx, aw_cnt - aw0));
      assert (cap_aw.addr == base)
         else report_error($sformatf("case %0d aw.addr %h, expected %h", idx, cap_aw.addr, base));
      assert (int'(cap_aw.len) == beats - 1)
         else report_error($sformatf("case %0d aw.len %0d, expected %0d",
                                     idx, cap_aw.len, beats - 1));
      assert (cap_aw.size == 3'd2 && cap_aw.burst == 2'd1 && cap_aw.cache == 4'd2 &&
              cap_aw.prot == 3'd2)
         else report_error($sformatf("case %0d AW attributes wrong", idx));
      assert (w_cnt - w0 == beats)
         else report_error($sformatf("case %0d W beats %0d, expected %0d",
                                     idx, w_cnt - w0, beats));
      assert (last_cnt - last0 == 1 && last_pos == beats - 1)
         else report_error($sformatf("case %0d w.last on beat %0d, expected %0d",
                                     idx, last_pos, beats - 1));
      assert (b_cnt - b0 == 1 && !b_ready)
         else report_error($sformatf("case %0d saw %0d B transfers, b_ready %0b",
                                     idx, b_cnt - b0, b_ready));

      // Frame bytes in range, fill pattern on both edges
      for (int i = 0; i < beats * 4; i++) begin
         a = base + 32'(i);
         got = u_mem.mem[13'(a)];
         if (a >= tc.addr && a < tc.addr + 32'(tc.len)) begin
            expect_byte = frame[10'(a - tc.addr)];
         end else begin
            expect_byte = 8'hA5;
         end
         assert (got == expect_byte || mem_bad) else begin
            report_error($sformatf("case %0d memory byte %h is %h, expected %h",
                                   idx, a, got, expect_byte));
            mem_bad = 1'b1;
         end
      end

      if (errors == err0) begin
         $display("Case %0d addr %h len %0d stall %0b: passed", idx, tc.addr, tc.len, tc.stall);
      end else begin
         failed_cases++;
         $display("Case %0d addr %h len %0d stall %0b: FAILED", idx, tc.addr, tc.len, tc.stall);
      end
   endtask

   function automatic int watchdog_cycles();
      int total;
      total = 4;
      for (int i = 0; i < N_CASES; i++) begin
         total += (int'(CASES[4'(i)].len) / 4 + 20) * 5;
      end
      return total;
   endfunction

   initial begin
      repeat (watchdog_cycles()) @(posedge clk);
      $display("Timeout: the DMA copies did not finish within %0d cycles", watchdog_cycles());
      $display("Test failed");
      $finish;
   end

   initial begin
      void'($urandom(63182));
      rst        = 1'b1;
      run        = 1'b0;
      cfg        = '0;
      buf_wr     = '0;
      stall_en   = 1'b0;
      fill_en    = 1'b0;
      fill_base  = '0;
      fill_count = '0;
      errors       = 0;
      failed_cases = 0;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      assert (!aw_valid && !w_valid && !b_ready && ready)
         else report_error("outputs after reset not idle");

      for (int i = 0; i < N_CASES; i++) begin
         run_case(i, CASES[4'(i)]);
      end

      $display("Cases run %0d, failed %0d, errors %0d", N_CASES, failed_cases, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== eth_dma.f ====
design/axi_pkg.sv
design/eth_dma_pkg.sv
design/eth_rx_buffer.sv
design/eth_burst_split.sv
design/eth_dma_w.sv
design/eth_dma_top.sv
bench/axi_mem_slave.sv
bench/tb_eth_dma.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the receive DMA testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f eth_dma.f --top-module tb_eth_dma -Mdir obj_dir -o sim_eth_dma

out="$(./obj_dir/sim_eth_dma)"
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
   exit 0
fi
exit 1
